//--- hdl/v2t_cfg_pkg.sv
/*
 * V2T channel configuration
 * Widths of the input code, discharge level, current control word and
 * result counter, plus the default gain, threshold and offset used by
 * the channel top level.
 */

package v2t_cfg_pkg;

    ////////////////////////////////////////////////////////////
    // code and level widths
    ////////////////////////////////////////////////////////////

    localparam int vin_width   = 8;                 // sampled input code
    localparam int level_width = 12;                // discharge level, holds vin*gain>>shift
    localparam int gain_shift  = 2;                 // right shift after the gain multiply

    ////////////////////////////////////////////////////////////
    // current control word
    ////////////////////////////////////////////////////////////

    localparam int nv2t      = 4;                   // log2 of control word width
    localparam int ctl_width = 2 ** nv2t;           // thermometer bits, one per unit source

    ////////////////////////////////////////////////////////////
    // time-to-digital counter
    ////////////////////////////////////////////////////////////

    localparam int tdc_width = 10;                  // result width, saturates at all ones

    // top-level parameter defaults
    localparam int default_gain   = 5;              // hold gain before the shift
    localparam int default_vlth   = 64;             // comparator threshold in level codes
    localparam int default_offset = 3;              // fixed comparator delay in cycles

endpackage

//--- hdl/v2t_therm_pkg.sv
/*
 * Thermometer code helpers
 * The ramp step is the number of enabled unit current sources, i.e. the
 * popcount of the control word. A proper thermometer code has its ones
 * packed from bit 0 upward with no gaps.
 */

package v2t_therm_pkg;

    localparam int step_width = v2t_cfg_pkg::nv2t + 1; // 0 .. ctl_width ones

    ////////////////////////////////////////////////////////////
    // step_of
    ////////////////////////////////////////////////////////////

    function automatic logic [step_width-1:0] step_of(
        input logic [v2t_cfg_pkg::ctl_width-1:0] ctl
    );
        logic [step_width-1:0] ones;                // running popcount
        ones = '0;
        for (int i = 0; i < v2t_cfg_pkg::ctl_width; i++) begin
            ones = ones + step_width'(ctl[i]);      // one unit source per set bit
        end
        return ones;
    endfunction

    ////////////////////////////////////////////////////////////
    // therm_valid
    ////////////////////////////////////////////////////////////

    // ones packed from bit 0 means ctl+1 is a single bit above the run,
    // so the AND is empty; all ones wraps to zero and all zeros is valid too
    function automatic logic therm_valid(
        input logic [v2t_cfg_pkg::ctl_width-1:0] ctl
    );
        logic [v2t_cfg_pkg::ctl_width-1:0] nxt;     // ctl plus one, same width
        nxt = ctl + 1'b1;
        return ((ctl & nxt) == '0);
    endfunction

endpackage

//--- hdl/v2t_sample_hold.sv
/*
 * V2T sample and hold
 * Captures the input code on the sample strobe, then scales it by the
 * hold gain into the discharge level seen by the ramp engine. The level
 * is valid one cycle after the sample and holds until the next one.
 */

module v2t_sample_hold #(
    parameter int gain = v2t_cfg_pkg::default_gain  // hold gain
) (
    input  logic                                clk_v2t_lb, // conversion clock
    input  logic                                rst,        // sync, active high
    input  logic                                sample,     // one-cycle sample strobe
    input  logic [v2t_cfg_pkg::vin_width-1:0]   vin,        // input code
    output logic [v2t_cfg_pkg::level_width-1:0] level       // scaled discharge level
);

    localparam int vw = v2t_cfg_pkg::vin_width;
    localparam int sh = v2t_cfg_pkg::gain_shift;
    localparam int pw = v2t_cfg_pkg::level_width + sh;  // product before the shift

    logic [vw-1:0] vin_q;       // held input code
    logic          sample_d;    // sample strobe one cycle late
    logic [pw-1:0] prod;        // vin_q times gain

    ////////////////////////////////////////////////////////////
    // input switch
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_v2t_lb) begin
        if (sample) begin
            vin_q <= vin;                           // hold cap tracks vin only on sample
        end
    end

    ////////////////////////////////////////////////////////////
    // gain and shift
    ////////////////////////////////////////////////////////////

    assign prod = pw'(vin_q) * pw'(gain);          // fits, level_width covers max code

    always_ff @(posedge clk_v2t_lb) begin
        if (rst) begin
            sample_d <= 1'b0;
            level    <= '0;                         // empty cap after reset
        end else begin
            sample_d <= sample;
            if (sample_d) begin
                level <= prod[pw-1:sh];             // drop the fractional bits
            end
        end
    end

endmodule

//--- hdl/v2t_ramp.sv
/*
 * V2T ramp-down engine
 * Loads the held level on start and discharges it by the thermometer
 * step each cycle until it reaches the threshold. After a fixed offset
 * delay the output pulse rises and stays high until the next start or
 * precharge. Precharge overrides everything and clears the pulse.
 */

module v2t_ramp #(
    parameter int vlth   = v2t_cfg_pkg::default_vlth,   // threshold level
    parameter int offset = v2t_cfg_pkg::default_offset  // comparator delay, cycles
) (
    input  logic                                clk_v2t_lb, // conversion clock
    input  logic                                rst,        // sync, active high
    input  logic                                start,      // one-cycle ramp start
    input  logic                                precharge,  // level, abandons the ramp
    input  logic [v2t_cfg_pkg::ctl_width-1:0]   ctl,        // thermometer current control
    input  logic [v2t_cfg_pkg::level_width-1:0] level,      // held discharge level
    output logic                                v2t_out     // output pulse
);

    localparam int lw = v2t_cfg_pkg::level_width;
    localparam int sw = v2t_therm_pkg::step_width;
    localparam int dw = (offset > 1) ? $clog2(offset) : 1;  // delay counter width

    localparam logic [1:0] st_idle  = 2'd0;     // waiting for start
    localparam logic [1:0] st_ramp  = 2'd1;     // discharging
    localparam logic [1:0] st_delay = 2'd2;     // comparator offset delay
    localparam logic [1:0] st_fired = 2'd3;     // pulse high

    localparam logic [lw-1:0] vlth_lvl = lw'(vlth);
    localparam logic [dw-1:0] dly_load = dw'((offset > 0) ? offset - 1 : 0);

    logic [1:0]    state;       // ramp FSM
    logic [lw-1:0] work;        // discharging level
    logic [dw-1:0] dly_cnt;     // remaining delay cycles
    logic [sw-1:0] step;        // current for this cycle
    logic [lw-1:0] step_ext;    // step at level width
    logic [lw-1:0] work_next;   // level after one step
    logic          above;       // level still above threshold

    ////////////////////////////////////////////////////////////
    // discharge step
    ////////////////////////////////////////////////////////////

    // a malformed control word steers no current
    assign step      = v2t_therm_pkg::therm_valid(ctl) ? v2t_therm_pkg::step_of(ctl) : '0;
    assign step_ext  = {{(lw - sw){1'b0}}, step};
    assign work_next = (work > step_ext) ? work - step_ext : '0;  // floor at zero
    assign above     = (work > vlth_lvl);

    always_ff @(posedge clk_v2t_lb) begin
        if (start) begin
            work <= level;                          // flip cap onto the ramp node
        end else if (state == st_ramp && above) begin
            work <= work_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // FSM and pulse
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_v2t_lb) begin
        if (rst) begin
            state   <= st_idle;
            v2t_out <= 1'b0;
            dly_cnt <= '0;
        end else if (precharge) begin
            state   <= st_idle;                     // node pulled back up
            v2t_out <= 1'b0;
        end else if (start) begin
            state   <= st_ramp;                     // restart also lands here
            v2t_out <= 1'b0;
        end else begin
            case (state)
                st_ramp: begin
                    if (step_ext != '0 && !above) begin   // zero current never crosses
                        if (offset == 0) begin
                            state   <= st_fired;
                            v2t_out <= 1'b1;
                        end else begin
                            state   <= st_delay;
                            dly_cnt <= dly_load;
                        end
                    end
                end
                st_delay: begin
                    if (dly_cnt == '0) begin
                        state   <= st_fired;
                        v2t_out <= 1'b1;            // comparator output edge
                    end else begin
                        dly_cnt <= dly_cnt - 1'b1;
                    end
                end
                default: ;                          // idle and fired hold
            endcase
        end
    end

endmodule

//--- hdl/v2t_tdc.sv
/*
 * V2T time-to-digital counter
 * Clears on start and counts cycles until the pulse edge is seen. The
 * count then freezes into result and done pulses for one cycle. If the
 * count saturates first, result holds the maximum with overflow set.
 */

module v2t_tdc (
    input  logic                              clk_v2t_lb, // conversion clock
    input  logic                              rst,        // sync, active high
    input  logic                              start,      // one-cycle conversion start
    input  logic                              v2t_out,    // pulse from the ramp
    output logic [v2t_cfg_pkg::tdc_width-1:0] result,     // measured cycles
    output logic                              overflow,   // result saturated
    output logic                              done        // one-cycle result strobe
);

    localparam int tw = v2t_cfg_pkg::tdc_width;
    localparam logic [tw-1:0] cnt_max = '1;

    logic          busy;        // conversion in flight
    logic          start_d;     // first cycle after start
    logic          v2t_d;       // pulse one cycle late
    logic          rise;        // pulse edge
    logic          sat;         // counter at maximum
    logic          counting;    // advance the counter this cycle
    logic [tw-1:0] cnt;         // running count

    ////////////////////////////////////////////////////////////
    // edge detect and count enable
    ////////////////////////////////////////////////////////////

    assign rise     = v2t_out & ~v2t_d;
    assign sat      = (cnt == cnt_max);
    // skip the cycle after start so the count excludes the pulse edge cycle
    assign counting = busy & ~start_d & ~start;

    always_ff @(posedge clk_v2t_lb) begin
        if (rst) begin
            busy     <= 1'b0;
            start_d  <= 1'b0;
            v2t_d    <= 1'b0;
            overflow <= 1'b0;
            done     <= 1'b0;
        end else begin
            v2t_d   <= v2t_out;
            start_d <= start;
            done    <= 1'b0;                        // pulse only
            if (start) begin
                busy     <= 1'b1;
                overflow <= 1'b0;
            end else if (busy && sat) begin         // saturation wins a tie with the edge
                busy     <= 1'b0;
                overflow <= 1'b1;
                done     <= 1'b1;
            end else if (busy && rise) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // counter and result
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_v2t_lb) begin
        if (start) begin
            cnt <= '0;
        end else if (counting && !rise && !sat) begin
            cnt <= cnt + 1'b1;
        end
        if (busy && !start && (rise || sat)) begin
            result <= cnt;                          // frozen until next conversion
        end
    end

endmodule

//--- hdl/v2t_channel.sv
/*
 * V2T channel top level
 * Sample-hold, ramp-down engine and time-to-digital counter for one
 * single-ended channel. Gain, threshold and offset are set here and
 * passed down.
 */

module v2t_channel #(
    parameter int gain   = v2t_cfg_pkg::default_gain,   // hold gain
    parameter int vlth   = v2t_cfg_pkg::default_vlth,   // ramp threshold
    parameter int offset = v2t_cfg_pkg::default_offset  // comparator delay
) (
    input  logic                              clk_v2t_lb, // conversion clock
    input  logic                              rst,        // sync, active high
    input  logic                              sample,     // sample strobe
    input  logic [v2t_cfg_pkg::vin_width-1:0] vin,        // input code
    input  logic                              start,      // ramp start strobe
    input  logic                              precharge,  // precharge level
    input  logic [v2t_cfg_pkg::ctl_width-1:0] ctl,        // thermometer current word
    output logic                              v2t_out,    // output pulse
    output logic [v2t_cfg_pkg::tdc_width-1:0] result,     // measured cycles
    output logic                              overflow,   // result saturated
    output logic                              done        // result strobe
);

    logic [v2t_cfg_pkg::level_width-1:0] level;    // held discharge level

    v2t_sample_hold #(
        .gain       (gain)
    ) sample_hold_i (
        .clk_v2t_lb (clk_v2t_lb),
        .rst        (rst),
        .sample     (sample),
        .vin        (vin),
        .level      (level)
    );

    v2t_ramp #(
        .vlth       (vlth),
        .offset     (offset)
    ) ramp_i (
        .clk_v2t_lb (clk_v2t_lb),
        .rst        (rst),
        .start      (start),                        // shared with the counter
        .precharge  (precharge),
        .ctl        (ctl),
        .level      (level),
        .v2t_out    (v2t_out)
    );

    v2t_tdc tdc_i (
        .clk_v2t_lb (clk_v2t_lb),
        .rst        (rst),
        .start      (start),
        .v2t_out    (v2t_out),                      // stop event
        .result     (result),
        .overflow   (overflow),
        .done       (done)
    );

endmodule

//--- tests/v2t_channel_asserts.sv
/*
 * V2T ramp assertions
 * Bound into the ramp engine. Checks that precharge and start clear
 * the pulse and that the current word is a thermometer code while the
 * ramp is discharging.
 */

module v2t_ramp_asserts (
    input logic                              clk_v2t_lb, // conversion clock
    input logic                              rst,        // sync, active high
    input logic                              start,      // ramp start strobe
    input logic                              precharge,  // precharge level
    input logic [v2t_cfg_pkg::ctl_width-1:0] ctl,        // current control word
    input logic                              v2t_out,    // output pulse
    input logic                              ramp_active // FSM in the ramp state
);

    int fail_count = 0;         // failed assertions so far

    ////////////////////////////////////////////////////////////
    // pulse clearing
    ////////////////////////////////////////////////////////////

    precharge_clears_a : assert property (
        @(posedge clk_v2t_lb) disable iff (rst) precharge |=> !v2t_out
    ) else begin
        fail_count++;
        $error("v2t_out high in the cycle after precharge");
    end

    start_clears_a : assert property (
        @(posedge clk_v2t_lb) disable iff (rst) start |=> !v2t_out
    ) else begin
        fail_count++;
        $error("v2t_out high in the cycle after start");
    end

    // control word while discharging
    ctl_therm_a : assert property (
        @(posedge clk_v2t_lb) disable iff (rst)
            ramp_active |-> v2t_therm_pkg::therm_valid(ctl)
    ) else begin
        fail_count++;
        $error("ctl is not a thermometer code during the ramp");
    end

endmodule

bind v2t_ramp v2t_ramp_asserts asserts_i (
    .clk_v2t_lb  (clk_v2t_lb),
    .rst         (rst),
    .start       (start),
    .precharge   (precharge),
    .ctl         (ctl),
    .v2t_out     (v2t_out),
    .ramp_active (state == st_ramp)
);

//--- tests/tb_v2t_channel.sv
/*
 * V2T channel testbench
 * Random and directed conversions through the sample-hold, ramp and
 * counter. A driver process pushes expected results from a reference
 * model into a queue; a comparing process pops them on each done.
 */

module tb_v2t_channel;

    localparam int vin_w       = v2t_cfg_pkg::vin_width;
    localparam int ctl_w       = v2t_cfg_pkg::ctl_width;
    localparam int tdc_w       = v2t_cfg_pkg::tdc_width;
    localparam int cnt_max     = (1 << tdc_w) - 1;          // counter saturation value
    localparam int tb_gain     = v2t_cfg_pkg::default_gain;
    localparam int tb_vlth     = v2t_cfg_pkg::default_vlth;
    localparam int tb_offset   = v2t_cfg_pkg::default_offset;
    localparam int n_random    = 200;
    localparam int done_limit  = 1200;      // zero current saturates after ~1025 cycles
    localparam int check_limit = 1500;
    localparam int idle_limit  = 5000;
    localparam int pre_window  = 300;       // must stay below the saturation time

    typedef logic [tdc_w:0] expect_t;       // {overflow, result}

    logic             clk_v2t_lb;
    logic             rst;
    logic             sample;
    logic [vin_w-1:0] vin;
    logic             start;
    logic             precharge;
    logic [ctl_w-1:0] ctl;
    logic             v2t_out;
    logic [tdc_w-1:0] result;
    logic             overflow;
    logic             done;

    expect_t          exp_q[$];             // pending expected results
    int               pushed;               // conversions expected to finish
    int               checks_done;          // conversions compared
    logic [vin_w-1:0] held_vin;             // code currently in the hold stage

    v2t_channel dut_i (
        .clk_v2t_lb (clk_v2t_lb),
        .rst        (rst),
        .sample     (sample),
        .vin        (vin),
        .start      (start),
        .precharge  (precharge),
        .ctl        (ctl),
        .v2t_out    (v2t_out),
        .result     (result),
        .overflow   (overflow),
        .done       (done)
    );

    initial begin
        clk_v2t_lb = 1'b0;
        forever #20 clk_v2t_lb = ~clk_v2t_lb;   // period 40
    end

    ////////////////////////////////////////////////////////////
    // reference model, checks and timeouts
    ////////////////////////////////////////////////////////////

    // level = vin*gain>>shift, n = ceil((level-vlth)/step), result = n+offset
    function automatic expect_t ref_conversion(
        input int               vin_code,
        input logic [ctl_w-1:0] ctl_word,
        input int               gain,
        input int               vlth,
        input int               offset
    );
        int level_code;
        int step;
        int n;
        int total;
        level_code = (vin_code * gain) >> v2t_cfg_pkg::gain_shift;
        step       = $countones(ctl_word);              // one unit source per bit
        if (step == 0) begin
            return {1'b1, tdc_w'(cnt_max)};             // pulse never rises
        end
        n     = (level_code > vlth) ? (level_code - vlth + step - 1) / step : 0;
        total = n + offset;
        if (total >= cnt_max) begin
            return {1'b1, tdc_w'(cnt_max)};
        end
        return {1'b0, tdc_w'(total)};
    endfunction

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("MISMATCH at time %0t: %s got %0d expected %0d",
                     $time, name, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout at time %0t: %s never came", $time, what);
        $display("Test failed");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////
    // comparing process
    ////////////////////////////////////////////////////////////

    initial begin : compare_proc
        expect_t exp;
        int      cyc;
        forever begin
            cyc = 0;
            while (exp_q.size() == 0) begin             // nothing in flight
                @(negedge clk_v2t_lb);
                if (done === 1'b1) begin
                    $display("done pulsed at time %0t with no conversion pending", $time);
                    $display("Test failed");
                    $fatal(1);
                end
                cyc++;
                if (cyc > idle_limit) abort_on_timeout("a new conversion");
            end
            cyc = 0;
            do begin
                @(negedge clk_v2t_lb);                  // outputs settled mid-cycle
                cyc++;
                if (cyc > done_limit) abort_on_timeout("done for the pending conversion");
            end while (done !== 1'b1);
            exp = exp_q.pop_front();
            check_value("result", int'(result), int'(exp[tdc_w-1:0]));
            check_value("overflow", int'(overflow), int'(exp[tdc_w]));
            checks_done++;
        end
    end

    ////////////////////////////////////////////////////////////
    // driver tasks
    ////////////////////////////////////////////////////////////

    task automatic take_sample(input logic [vin_w-1:0] code);
        @(negedge clk_v2t_lb);
        vin    = code;
        sample = 1'b1;
        @(negedge clk_v2t_lb);
        sample   = 1'b0;                                // level lands on the next edge
        held_vin = code;
    endtask

    task automatic launch(input logic [ctl_w-1:0] word, input bit expect_done,
                          input expect_t exp);
        @(negedge clk_v2t_lb);
        ctl   = word;
        start = 1'b1;
        if (expect_done) begin
            exp_q.push_back(exp);
            pushed++;
        end
        @(negedge clk_v2t_lb);
        start = 1'b0;
    endtask

    task automatic wait_for_check();
        int cyc;
        cyc = 0;
        while (checks_done != pushed) begin
            @(negedge clk_v2t_lb);
            cyc++;
            if (cyc > check_limit) abort_on_timeout("comparison of the last conversion");
        end
    endtask

    task automatic convert(input logic [ctl_w-1:0] word);
        launch(word, 1'b1, ref_conversion(held_vin, word, tb_gain, tb_vlth, tb_offset));
        wait_for_check();
    endtask

    function automatic logic [ctl_w-1:0] therm_word(input int ones);
        return ctl_w'((32'd1 << ones) - 1);             // ones packed from bit 0
    endfunction

    ////////////////////////////////////////////////////////////
    // driver process
    ////////////////////////////////////////////////////////////

    initial begin : drive_proc
        void'($urandom(37543));
        rst         = 1'b1;
        sample      = 1'b0;
        vin         = '0;
        start       = 1'b0;
        precharge   = 1'b0;
        ctl         = '0;
        pushed      = 0;
        checks_done = 0;
        held_vin    = '0;
        repeat (5) @(posedge clk_v2t_lb);               // five reset edges
        @(negedge clk_v2t_lb);
        rst = 1'b0;
        @(negedge clk_v2t_lb);
        check_value("v2t_out", int'(v2t_out), 0);       // reset state
        check_value("done", int'(done), 0);
        check_value("overflow", int'(overflow), 0);
        check_value("level", int'(dut_i.sample_hold_i.level), 0);

        for (int i = 0; i < n_random; i++) begin        // random conversions
            take_sample(vin_w'($urandom_range(0, (1 << vin_w) - 1)));
            convert(therm_word($urandom_range(1, ctl_w)));
        end

        take_sample(vin_w'(40));                        // level 50, below threshold
        launch(therm_word(4), 1'b1, {1'b0, tdc_w'(tb_offset)});
        wait_for_check();

        take_sample(vin_w'(200));                       // step is the popcount
        convert(therm_word(ctl_w));
        convert(therm_word(1));

        convert('0);                                    // zero current saturates

        take_sample(vin_w'(255));                       // long ramp, then precharge
        launch(therm_word(1), 1'b0, '0);
        repeat (10) @(negedge clk_v2t_lb);
        precharge = 1'b1;
        for (int i = 0; i < pre_window; i++) begin
            @(negedge clk_v2t_lb);
            check_value("v2t_out", int'(v2t_out), 0);
            check_value("done", int'(done), 0);
        end
        precharge = 1'b0;
        take_sample(vin_w'(150));
        convert(therm_word(3));

        take_sample(vin_w'(100));                       // resampling
        convert(therm_word(8));
        convert(therm_word(8));                         // no new sample, same code held
        take_sample(vin_w'(180));                       // new code, longer ramp
        convert(therm_word(8));

        wait_for_check();
        if (dut_i.ramp_i.asserts_i.fail_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

//--- compile.f
hdl/v2t_cfg_pkg.sv
hdl/v2t_therm_pkg.sv
hdl/v2t_sample_hold.sv
hdl/v2t_ramp.sv
hdl/v2t_tdc.sv
hdl/v2t_channel.sv
tests/v2t_channel_asserts.sv
tests/tb_v2t_channel.sv

//--- Bender.yml
package:
  name: v2t_channel

sources:
  # packages first, then RTL in dependency order
  - hdl/v2t_cfg_pkg.sv
  - hdl/v2t_therm_pkg.sv
  - hdl/v2t_sample_hold.sv
  - hdl/v2t_ramp.sv
  - hdl/v2t_tdc.sv
  - hdl/v2t_channel.sv
  - target: test
    files:
      - tests/v2t_channel_asserts.sv
      - tests/tb_v2t_channel.sv
